// ==== Makefile ====
# Verilator build and run of the stream byte-sum testbench

VERILATOR ?= verilator
TOP       := tb_stream_sum
FILELIST  := tb.f
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Passes only if the pass line appears in the output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(BUILD_DIR)

// ==== rtl/stream_byte_accum.sv ====
`timescale 1ns/1ns

/*
  Sums the strobed bytes of each group of BEATS_PER_SUM beats
  Disabled byte lanes add nothing to the sum and nothing to the count
  One result is held until taken and beats stall meanwhile
  Beats also stall in the cycle the result leaves as there is no bypass
  clear_i drops a partial group and any held result
*/
module stream_byte_accum (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  input  logic                beat_valid_i,
  input  stream_pkg::beat_t   beat_i,
  output logic                beat_ready_o,
  output logic                res_valid_o,
  output stream_pkg::result_t res_o,
  input  logic                res_ready_i
);

  logic [$clog2(stream_pkg::BEATS_PER_SUM)-1:0] beat_idx_q; // Position in group
  logic [stream_pkg::SUM_WIDTH-1:0] sum_q;    // Running sum
  logic [stream_pkg::SUM_WIDTH-1:0] sum_next;
  logic [stream_pkg::SUM_WIDTH-1:0] beat_sum; // This beat only
  logic [stream_pkg::SUM_WIDTH-1:0] byte_val;
  logic [stream_pkg::CNT_WIDTH-1:0] cnt_q;    // Running byte count
  logic [stream_pkg::CNT_WIDTH-1:0] cnt_next;
  logic [stream_pkg::CNT_WIDTH-1:0] beat_cnt;
  logic                             res_valid_q;
  stream_pkg::result_t              res_q;
  logic                             beat_acc;
  logic                             last_beat;

  // Per-beat byte sum and lane count
  always_comb begin
    beat_sum = '0;
    beat_cnt = '0;
    byte_val = '0;
    for (int b = 0; b < stream_pkg::STRB_WIDTH; b++) begin
      byte_val      = '0;
      byte_val[7:0] = beat_i.data[8*b +: 8]; // Zero-extended lane
      if (beat_i.strb[b]) begin
        beat_sum = beat_sum + byte_val;
        beat_cnt = beat_cnt + 1'b1;
      end
    end
  end

  assign sum_next  = sum_q + beat_sum;
  assign cnt_next  = cnt_q + beat_cnt;
  assign beat_acc  = beat_valid_i & beat_ready_o;
  assign last_beat = (beat_idx_q == stream_pkg::BEATS_PER_SUM - 1); // Closing beat

  // Group progress and result handshake
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_idx_q  <= '0;
      sum_q       <= '0;
      cnt_q       <= '0;
      res_valid_q <= 1'b0;
    end else if (clear_i) begin
      beat_idx_q  <= '0;
      sum_q       <= '0;
      cnt_q       <= '0;
      res_valid_q <= 1'b0;
    end else if (beat_acc) begin
      if (last_beat) begin
        beat_idx_q  <= '0; // Restart for the next group
        sum_q       <= '0;
        cnt_q       <= '0;
        res_valid_q <= 1'b1;
      end else begin
        beat_idx_q <= beat_idx_q + 1'b1;
        sum_q      <= sum_next;
        cnt_q      <= cnt_next;
      end
    end else if (res_valid_q && res_ready_i) begin
      res_valid_q <= 1'b0; // Taken by the output FIFO
    end
  end

  // Held result loaded on the closing beat
  always_ff @(posedge clk_i) begin
    if (beat_acc && last_beat) begin
      res_q.sum   <= sum_next;
      res_q.count <= cnt_next;
    end
  end

  assign beat_ready_o = ~res_valid_q; // Stalls until a cycle after hand-off
  assign res_valid_o  = res_valid_q;
  assign res_o        = res_q;

  // A held result stays stable and keeps the beat side stalled
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_o && !res_ready_i && !clear_i |=>
      res_valid_o && !beat_ready_o && $stable(res_o));

  // At most 255 per counted byte and at most one group of lanes counted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_o |-> (res_o.count <= stream_pkg::BEATS_PER_SUM * stream_pkg::STRB_WIDTH) &&
                    (res_o.sum <= 255 * res_o.count));

endmodule

// ==== rtl/stream_fifo.sv ====
`timescale 1ns/1ns

/*
  Single-clock FIFO with valid/ready on both sides and no fall-through
  An item pushed at one edge is poppable from the next cycle on
  DEPTH must be 2 or more and need not be a power of two
  clear_i empties the queue at the next edge and leaves storage as is
  Pop data reads zero whenever pop_valid_o is low
*/
module stream_fifo #(
  parameter int unsigned DEPTH     = 8,
  parameter type         payload_t = logic [31:0]
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,
  input  logic     push_valid_i,
  input  payload_t push_data_i,
  output logic     push_ready_o,
  output logic     pop_valid_o,
  output payload_t pop_data_o,
  input  logic     pop_ready_i,
  output logic     empty_o,
  output logic     full_o
);

  localparam int unsigned ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef enum logic [1:0] {
    EMPTY,
    MIDDLE,
    FULL
  } state_e;

  state_e            state_q, state_d;
  logic [ADDR_W-1:0] push_ptr_q, push_ptr_d; // Next slot to write
  logic [ADDR_W-1:0] pop_ptr_q, pop_ptr_d;   // Oldest stored item
  logic [ADDR_W-1:0] push_ptr_inc, pop_ptr_inc;
  logic              push_acc;
  payload_t          mem_q [DEPTH];

  // Increment with wrap at DEPTH-1 so odd depths work too
  function automatic logic [ADDR_W-1:0] wrap_inc(input logic [ADDR_W-1:0] ptr);
    return (ptr == ADDR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push_ptr_inc = wrap_inc(push_ptr_q);
  assign pop_ptr_inc  = wrap_inc(pop_ptr_q);

  // State and pointers with clear acting like reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= EMPTY;
      push_ptr_q <= '0;
      pop_ptr_q  <= '0;
    end else if (clear_i) begin
      state_q    <= EMPTY;
      push_ptr_q <= '0;
      pop_ptr_q  <= '0;
    end else begin
      state_q    <= state_d;
      push_ptr_q <= push_ptr_d;
      pop_ptr_q  <= pop_ptr_d;
    end
  end

  // Handshake outputs depend on state only
  always_comb begin
    push_ready_o = 1'b0;
    pop_valid_o  = 1'b0;
    case (state_q)
      EMPTY: begin
        push_ready_o = 1'b1;
      end
      MIDDLE: begin
        push_ready_o = 1'b1;
        pop_valid_o  = 1'b1;
      end
      FULL: begin
        pop_valid_o = 1'b1;
      end
      default: begin
        push_ready_o = 1'b0;
        pop_valid_o  = 1'b0;
      end
    endcase
  end

  // Next state and pointer moves
  always_comb begin
    state_d    = state_q;
    push_ptr_d = push_ptr_q;
    pop_ptr_d  = pop_ptr_q;
    case (state_q)
      EMPTY: begin
        if (push_valid_i) begin
          state_d    = MIDDLE; // One item never fills as DEPTH >= 2
          push_ptr_d = push_ptr_inc;
        end
      end
      MIDDLE: begin
        case ({push_valid_i, pop_ready_i})
          2'b01: begin
            pop_ptr_d = pop_ptr_inc;
            if (pop_ptr_inc == push_ptr_q) begin
              state_d = EMPTY; // Last item leaves
            end
          end
          2'b10: begin
            push_ptr_d = push_ptr_inc;
            if (push_ptr_inc == pop_ptr_q) begin
              state_d = FULL; // Write pointer catches up
            end
          end
          2'b11: begin
            push_ptr_d = push_ptr_inc; // Occupancy unchanged
            pop_ptr_d  = pop_ptr_inc;
          end
          default: begin
            state_d = MIDDLE;
          end
        endcase
      end
      FULL: begin
        if (pop_ready_i) begin
          state_d   = MIDDLE; // Push is blocked here
          pop_ptr_d = pop_ptr_inc;
        end
      end
      default: begin
        state_d    = EMPTY;
        push_ptr_d = '0;
        pop_ptr_d  = '0;
      end
    endcase
  end

  assign push_acc = push_valid_i & push_ready_o;

  // Storage written at the push pointer
  always_ff @(posedge clk_i) begin
    if (push_acc) begin
      mem_q[push_ptr_q] <= push_data_i;
    end
  end

  assign pop_data_o = pop_valid_o ? mem_q[pop_ptr_q] : payload_t'('0); // Zero when idle
  assign empty_o    = (state_q == EMPTY);
  assign full_o     = (state_q == FULL);

  // No push taken while full and the write pointer sits on the oldest item
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    full_o |-> !push_acc && (push_ptr_q == pop_ptr_q));

  // Nothing shows in EMPTY and both pointers meet
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    empty_o |-> !pop_valid_o && (push_ptr_q == pop_ptr_q));
  // A push into EMPTY is poppable one cycle later
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    empty_o && push_valid_i && !clear_i |=> pop_valid_o && pop_data_o == $past(push_data_i));

endmodule

// ==== rtl/stream_pkg.sv ====
/*
  Shared widths, FIFO depths and payload types of the byte-summing stream
  SUM_WIDTH and CNT_WIDTH are sized for BEATS_PER_SUM * STRB_WIDTH bytes
  Recheck both if the group length or the strobe width changes
  Each strobe bit covers exactly one 8-bit byte of data
*/
package stream_pkg;

  // Beat format
  localparam int unsigned DATA_WIDTH = 32;            // Beat data bits
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8; // One strobe bit per byte

  // Grouping
  localparam int unsigned BEATS_PER_SUM = 4; // Beats folded into one result

  // Queue sizes
  localparam int unsigned IN_FIFO_DEPTH  = 8; // Producer side slack
  localparam int unsigned OUT_FIFO_DEPTH = 4; // Consumer side slack

  // Result widths
  // 16 bytes of 255 at most, so 12 bits would do
  localparam int unsigned SUM_WIDTH = 16;
  // Count runs 0 to 16, hence 5 bits
  localparam int unsigned CNT_WIDTH = 5;

  // Input beat, pushed into the input FIFO as one word
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data; // Byte lanes, lane 0 in the low bits
    logic [STRB_WIDTH-1:0] strb; // Lane enables
  } beat_t;

  // One result per group of beats
  typedef struct packed {
    logic [SUM_WIDTH-1:0] sum;   // Sum of enabled bytes
    logic [CNT_WIDTH-1:0] count; // Number of enabled bytes
  } result_t;

  // Nothing below is shared logic
  // The package only carries constants and types

endpackage

// ==== rtl/stream_sum_top.sv ====
`timescale 1ns/1ns

/*
  Byte-summing stream engine between an input and an output FIFO
  Latency varies with back-pressure and is about 3 cycles at best
  One result per BEATS_PER_SUM accepted input beats, in order
  out_sum_o and out_count_o read zero while out_valid_o is low
*/
module stream_sum_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             clear_i,
  input  logic                             in_valid_i,
  input  logic [stream_pkg::DATA_WIDTH-1:0] in_data_i,
  input  logic [stream_pkg::STRB_WIDTH-1:0] in_strb_i,
  output logic                             in_ready_o,
  output logic                             out_valid_o,
  output logic [stream_pkg::SUM_WIDTH-1:0]  out_sum_o,
  output logic [stream_pkg::CNT_WIDTH-1:0]  out_count_o,
  input  logic                             out_ready_i,
  output logic                             in_full_o,
  output logic                             out_empty_o
);

  stream_pkg::beat_t   in_beat;   // Packed producer fields
  stream_pkg::beat_t   acc_beat;  // Input FIFO to accumulator
  logic                acc_beat_valid;
  logic                acc_beat_ready;
  stream_pkg::result_t acc_res;   // Accumulator to output FIFO
  logic                acc_res_valid;
  logic                acc_res_ready;
  stream_pkg::result_t out_res;   // Output FIFO pop side

  assign in_beat.data = in_data_i;
  assign in_beat.strb = in_strb_i;

  // Producer side slack
  stream_fifo #(
    .DEPTH     (stream_pkg::IN_FIFO_DEPTH),
    .payload_t (stream_pkg::beat_t)
  ) u_in_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .push_valid_i (in_valid_i),
    .push_data_i  (in_beat),
    .push_ready_o (in_ready_o),
    .pop_valid_o  (acc_beat_valid),
    .pop_data_o   (acc_beat),
    .pop_ready_i  (acc_beat_ready),
    .empty_o      (),
    .full_o       (in_full_o)
  );

  stream_byte_accum u_accum (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .beat_valid_i (acc_beat_valid),
    .beat_i       (acc_beat),
    .beat_ready_o (acc_beat_ready),
    .res_valid_o  (acc_res_valid),
    .res_o        (acc_res),
    .res_ready_i  (acc_res_ready)
  );

  // Consumer side slack
  stream_fifo #(
    .DEPTH     (stream_pkg::OUT_FIFO_DEPTH),
    .payload_t (stream_pkg::result_t)
  ) u_out_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .push_valid_i (acc_res_valid),
    .push_data_i  (acc_res),
    .push_ready_o (acc_res_ready),
    .pop_valid_o  (out_valid_o),
    .pop_data_o   (out_res),
    .pop_ready_i  (out_ready_i),
    .empty_o      (out_empty_o),
    .full_o       ()
  );

  assign out_sum_o   = out_res.sum;
  assign out_count_o = out_res.count;

endmodule

// ==== tb.f ====
rtl/stream_pkg.sv
rtl/stream_fifo.sv
rtl/stream_byte_accum.sv
rtl/stream_sum_top.sv
verification/tb_stream_sum.sv

// ==== verification/tb_stream_sum.sv ====
`timescale 1ns/1ns

/*
  Random producer and consumer around stream_sum_top with a byte-sum model
  All random draws come from one process, seeded once
  Inputs change 2 ns after the rising edge, outputs are sampled at the falling edge
  Stops at the first failed check
*/
module tb_stream_sum;

  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DLY   = 2;  // Input skew after the rising edge
  localparam int RST_CYCLES  = 16;
  localparam int GROUPS_A    = 60; // Results per random phase
  localparam int GROUPS_B    = 60;
  localparam int GROUPS_C    = 60;
  localparam int STALL_CYCLES = 80;
  localparam int GROUP_BOUND = 64; // Worst cycles per result at low rates
  localparam int WATCHDOG_CYCLES = RST_CYCLES + 2 * STALL_CYCLES +
                                   (GROUPS_A + GROUPS_B + GROUPS_C + 20) * GROUP_BOUND;
  // Beats the DUT takes with the output blocked, starting from an empty pipe
  localparam int unsigned STALL_ROOM =
    (stream_pkg::OUT_FIFO_DEPTH + 1) * stream_pkg::BEATS_PER_SUM + stream_pkg::IN_FIFO_DEPTH;

  logic                              clk_i;
  logic                              rst_ni;
  logic                              clear_i;
  logic                              in_valid_i;
  logic [stream_pkg::DATA_WIDTH-1:0] in_data_i;
  logic [stream_pkg::STRB_WIDTH-1:0] in_strb_i;
  logic                              in_ready_o;
  logic                              out_valid_o;
  logic [stream_pkg::SUM_WIDTH-1:0]  out_sum_o;
  logic [stream_pkg::CNT_WIDTH-1:0]  out_count_o;
  logic                              out_ready_i;
  logic                              in_full_o;
  logic                              out_empty_o;

  // Reference model state
  logic [stream_pkg::SUM_WIDTH-1:0] model_sum;
  logic [stream_pkg::CNT_WIDTH-1:0] model_cnt;
  int unsigned                      model_idx;  // Beats in the open group
  logic [stream_pkg::SUM_WIDTH-1:0] exp_sum_q[$];
  logic [stream_pkg::CNT_WIDTH-1:0] exp_cnt_q[$];

  // Traffic control
  int unsigned prod_pct;      // Chance of a new beat, percent
  int unsigned cons_pct;      // Chance of out_ready_i, percent
  logic        prod_finish;   // Only complete the open group
  logic        in_taken;      // Beat transfer at the coming edge
  int unsigned beats_taken;
  int unsigned results_seen;
  string       test_name;

  stream_sum_top u_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .in_valid_i  (in_valid_i),
    .in_data_i   (in_data_i),
    .in_strb_i   (in_strb_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_sum_o   (out_sum_o),
    .out_count_o (out_count_o),
    .out_ready_i (out_ready_i),
    .in_full_o   (in_full_o),
    .out_empty_o (out_empty_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Wrong value, shows expected and actual
  task automatic mismatch(input string what, input string exp, input string act);
    $display("Error in %s: %s expected %s, actual %s", test_name, what, exp, act);
    $display("Errors found");
    $fatal(1, "Run stopped at the first failed check");
  endtask

  task automatic abort_run(input string msg);
    $display("Failure in %s: %s", test_name, msg);
    $display("Errors found");
    $fatal(1, "Run stopped at the first failed check");
  endtask

  // A quarter empty, a quarter full, the rest random
  function automatic logic [stream_pkg::STRB_WIDTH-1:0] pick_strobe();
    logic [31:0] r;
    r = $urandom;
    case (r[1:0])
      2'd0:    pick_strobe = '0;
      2'd1:    pick_strobe = '1;
      default: pick_strobe = r[8 +: stream_pkg::STRB_WIDTH];
    endcase
  endfunction

  // Adds the enabled byte lanes of one accepted beat
  task automatic model_beat(input logic [stream_pkg::DATA_WIDTH-1:0] data,
                            input logic [stream_pkg::STRB_WIDTH-1:0] strb);
    logic [stream_pkg::SUM_WIDTH-1:0] lane;
    for (int b = 0; b < stream_pkg::STRB_WIDTH; b++) begin
      lane      = '0;
      lane[7:0] = data[8*b +: 8];
      if (strb[b]) begin
        model_sum = model_sum + lane;
        model_cnt = model_cnt + 1'b1;
      end
    end
    model_idx++;
    if (model_idx == stream_pkg::BEATS_PER_SUM) begin  // Group closed
      exp_sum_q.push_back(model_sum);
      exp_cnt_q.push_back(model_cnt);
      model_sum = '0;
      model_cnt = '0;
      model_idx = 0;
    end
  endtask

  task automatic model_reset();
    model_sum = '0;
    model_cnt = '0;
    model_idx = 0;
    exp_sum_q.delete();
    exp_cnt_q.delete();
  endtask

  // Handshakes as they will be seen at the next rising edge
  task automatic sample_and_check();
    logic [stream_pkg::SUM_WIDTH-1:0] exp_s;
    logic [stream_pkg::CNT_WIDTH-1:0] exp_c;
    assert (out_empty_o == !out_valid_o)
      else abort_run("out_empty_o does not mirror out_valid_o");
    assert (in_full_o == !in_ready_o)
      else abort_run("in_full_o does not mirror in_ready_o");
    if (!out_valid_o) begin
      assert (out_sum_o == '0 && out_count_o == '0)
        else abort_run("output payload is not zero while out_valid_o is low");
    end
    in_taken = in_valid_i && in_ready_o;
    if (in_taken) begin
      model_beat(in_data_i, in_strb_i);
      beats_taken++;
    end
    if (out_valid_o && out_ready_i) begin
      assert (exp_sum_q.size() != 0)
        else abort_run("a result came out that no input group accounts for");
      exp_s = exp_sum_q.pop_front();
      exp_c = exp_cnt_q.pop_front();
      assert (out_sum_o == exp_s)
        else mismatch("sum", $sformatf("%0d", exp_s), $sformatf("%0d", out_sum_o));
      assert (out_count_o == exp_c)
        else mismatch("count", $sformatf("%0d", exp_c), $sformatf("%0d", out_count_o));
      results_seen++;
    end
  endtask

  // One clock of producer, consumer and checks
  task automatic cycle_step();
    logic want_new;
    @(posedge clk_i);
    #DRIVE_DLY;
    if (!in_valid_i || in_taken) begin  // Holds an item until accepted
      want_new = prod_finish ? (model_idx != 0) : (($urandom % 100) < prod_pct);
      in_valid_i = want_new;
      in_data_i  = want_new ? $urandom : '0;
      in_strb_i  = want_new ? pick_strobe() : '0;
    end
    out_ready_i = (($urandom % 100) < cons_pct);
    @(negedge clk_i);
    sample_and_check();
  endtask

  task automatic run_groups(input int unsigned n, input int unsigned pp, input int unsigned cp);
    int unsigned target;
    target   = results_seen + n;
    prod_pct = pp;
    cons_pct = cp;
    while (results_seen < target) cycle_step();
  endtask

  // Closes the open group, then empties the pipe
  task automatic finish_and_drain();
    prod_finish = 1'b1;
    cons_pct    = 100;
    do cycle_step(); while (model_idx != 0 || in_valid_i);
    prod_finish = 1'b0;
    prod_pct    = 0;
    while (exp_sum_q.size() != 0) cycle_step();
  endtask

  task automatic stall_outputs();
    int unsigned start;
    start    = beats_taken;
    prod_pct = 100;
    cons_pct = 0;
    repeat (STALL_CYCLES) cycle_step();
    assert (!in_ready_o && in_full_o)
      else abort_run("in_ready_o stayed high with the output blocked");
    assert (beats_taken - start == STALL_ROOM)
      else mismatch("beats held", $sformatf("%0d", STALL_ROOM),
                    $sformatf("%0d", beats_taken - start));
    prod_pct = 0;
    cons_pct = 100;
    while (exp_sum_q.size() != 0) cycle_step(); // Held results drain in order
  endtask

  // Clear with both handshakes idle, pending beat is dropped
  task automatic apply_clear();
    @(posedge clk_i);
    #DRIVE_DLY;
    clear_i     = 1'b1;
    in_valid_i  = 1'b0;
    in_data_i   = '0;
    in_strb_i   = '0;
    out_ready_i = 1'b0;
    @(posedge clk_i);
    #DRIVE_DLY;
    clear_i = 1'b0;
    model_reset();
    @(negedge clk_i);
    in_taken = 1'b0;
    assert (!out_valid_o && out_empty_o && in_ready_o)
      else abort_run("queues not empty in the cycle after clear_i");
  endtask

  // Watchdog sized from the number of groups
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired during %s, the DUT stopped making progress", test_name);
    $display("Errors found");
    $fatal(1, "Run aborted by the watchdog");
  end

  initial begin
    void'($urandom(32'h8163_fec8));
    rst_ni       = 1'b0;
    clear_i      = 1'b0;
    in_valid_i   = 1'b0;
    in_data_i    = '0;
    in_strb_i    = '0;
    out_ready_i  = 1'b0;
    prod_pct     = 0;
    cons_pct     = 0;
    prod_finish  = 1'b0;
    in_taken     = 1'b0;
    beats_taken  = 0;
    results_seen = 0;
    test_name    = "reset_values";
    model_reset();
    repeat (RST_CYCLES) @(posedge clk_i);
    #DRIVE_DLY;
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (in_ready_o && !out_valid_o && out_empty_o && !in_full_o)
      else abort_run("handshake flags wrong after reset");

    test_name = "random_traffic";
    run_groups(GROUPS_A, 70, 60);
    finish_and_drain();

    test_name = "back_pressure";
    stall_outputs();
    run_groups(GROUPS_B, 80, 50);

    test_name = "mid_run_clear";
    prod_pct = 70;
    cons_pct = 40;
    repeat (37) cycle_step(); // Leaves partial groups and queued results
    apply_clear();
    run_groups(GROUPS_C, 60, 70);
    finish_and_drain();

    $display("No errors");
    $finish;
  end

endmodule
